/* logic/vecgen_pkg.sv */
// shared constants for the vector generator, referenced by scoped name from each design file
package vecgen_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////
    localparam int LEVEL_W = 8;     // channel level and each entry parameter
    localparam int OP_W    = 3;
    localparam int WORD_W  = 32;    // one program entry as seen on the bus

    // opcodes
    localparam logic [OP_W-1:0] OP_NOP    = 3'd0;
    localparam logic [OP_W-1:0] OP_LINE   = 3'd1;
    localparam logic [OP_W-1:0] OP_INCR   = 3'd2;
    localparam logic [OP_W-1:0] OP_DCRE   = 3'd3;
    localparam logic [OP_W-1:0] OP_JUMP   = 3'd4;
    localparam logic [OP_W-1:0] OP_X_RECT = 3'd5;
    localparam logic [OP_W-1:0] OP_Y_RECT = 3'd6;
    localparam logic [OP_W-1:0] OP_LINE_D = 3'd7;

    // field positions inside an entry word
    // bits 31..27 stay zero
    localparam int OP_LSB = 24;
    localparam int PA_LSB = 16;
    localparam int PB_LSB = 8;
    localparam int PC_LSB = 0;

    ////////////////////////////////////////
    // bus address map
    ////////////////////////////////////////
    localparam int AXI_ADDR_W    = 8;
    localparam int ADDR_IDX_LSB  = 2;   // entries are word aligned
    localparam int ADDR_CHAN_BIT = 6;   // 0 selects x, 1 selects y

    localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR = 8'h80;
    localparam int CTRL_RUN_BIT     = 0;
    localparam int CTRL_RESTART_BIT = 1;  // clears itself after one clock

    // response codes
    localparam int RESP_W = 2;
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

endpackage

/* logic/vecgen_ifs.sv */
// internal interfaces of the vector generator, the program write path and the channel handshake
`timescale 1ns/1ps

// one entry write from the bus port into the program store
interface prog_wr_if #(
    parameter int PROG_DEPTH = 16
);
    logic                          we;     // write strobe, one clock per entry
    logic                          chan;   // 0 is x, 1 is y
    logic [$clog2(PROG_DEPTH)-1:0] index;
    logic [vecgen_pkg::WORD_W-1:0] word;

    modport loader (output we, chan, index, word);
    modport store  (input  we, chan, index, word);
endinterface

// step handshake between the sequencer and one channel engine
interface chan_step_if;
    logic run;
    logic restart;  // one clock pulse
    logic ack;      // one clock pulse, only while both channels are done
    logic done;     // entry finished, held until ack

    modport ctrl   (output run, restart, ack, input done);
    modport engine (input run, restart, ack, output done);
endinterface

/* logic/axil_prog_port.sv */
// AXI4-Lite slave that loads and reads back program entries and holds the run/restart control
`timescale 1ns/1ps

module axil_prog_port #(
    parameter int PROG_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [vecgen_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [vecgen_pkg::WORD_W-1:0]     wdata,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [vecgen_pkg::RESP_W-1:0]     bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [vecgen_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [vecgen_pkg::WORD_W-1:0]     rdata,
    output logic [vecgen_pkg::RESP_W-1:0]     rresp,
    output logic                              rvalid,
    input  logic                              rready,
    input  logic [vecgen_pkg::WORD_W-1:0]     rd_word,   // readback from the store
    output logic                              rd_chan,
    output logic [$clog2(PROG_DEPTH)-1:0]     rd_index,
    output logic                              run,
    output logic                              restart,
    prog_wr_if.loader                         prog_wr
);

    localparam int IDX_W = $clog2(PROG_DEPTH);

    logic aw_rdy;       // shared by awready and wready
    logic wr_fire;
    logic rd_fire;
    logic wr_entry, wr_ctrl;
    logic rd_entry, rd_ctrl;

    // word aligned, below the control register, and inside the program depth
    function automatic logic is_entry(input logic [vecgen_pkg::AXI_ADDR_W-1:0] addr);
        return !addr[vecgen_pkg::AXI_ADDR_W-1]
            && (addr[vecgen_pkg::ADDR_IDX_LSB-1:0] == '0)
            && (addr[vecgen_pkg::ADDR_CHAN_BIT-1:vecgen_pkg::ADDR_IDX_LSB] < PROG_DEPTH);
    endfunction

    assign awready  = aw_rdy;
    assign wready   = aw_rdy;
    assign wr_fire  = aw_rdy && awvalid && wvalid;
    assign rd_fire  = arready && arvalid;
    assign wr_entry = is_entry(awaddr);
    assign wr_ctrl  = (awaddr == vecgen_pkg::CTRL_ADDR);
    assign rd_entry = is_entry(araddr);
    assign rd_ctrl  = (araddr == vecgen_pkg::CTRL_ADDR);

    assign prog_wr.we    = wr_fire && wr_entry;
    assign prog_wr.chan  = awaddr[vecgen_pkg::ADDR_CHAN_BIT];
    assign prog_wr.index = awaddr[vecgen_pkg::ADDR_IDX_LSB +: IDX_W];
    assign prog_wr.word  = wdata;

    assign rd_chan  = araddr[vecgen_pkg::ADDR_CHAN_BIT];    // store read is combinational
    assign rd_index = araddr[vecgen_pkg::ADDR_IDX_LSB +: IDX_W];

    ////////////////////////////////////////
    // handshakes and control register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            aw_rdy  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            run     <= 1'b0;
            restart <= 1'b0;
        end else begin
            aw_rdy  <= awvalid && wvalid && !aw_rdy && !bvalid;  // no accept while b is held
            arready <= arvalid && !arready && !rvalid;
            restart <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (wr_ctrl) begin
                    run     <= wdata[vecgen_pkg::CTRL_RUN_BIT];
                    restart <= wdata[vecgen_pkg::CTRL_RESTART_BIT];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= (wr_entry || wr_ctrl) ? vecgen_pkg::RESP_OKAY : vecgen_pkg::RESP_SLVERR;
        if (rd_fire) begin
            rresp <= (rd_entry || rd_ctrl) ? vecgen_pkg::RESP_OKAY : vecgen_pkg::RESP_SLVERR;
            if (rd_entry)
                rdata <= rd_word;
            else if (rd_ctrl)
                rdata <= {{(vecgen_pkg::WORD_W-1){1'b0}}, run};  // restart reads as 0
            else
                rdata <= '0;
        end
    end

endmodule

/* logic/program_store.sv */
// program memory for the x and y channels, one bus write port and three combinational reads
`timescale 1ns/1ps

module program_store #(
    parameter int PROG_DEPTH = 16
) (
    input  logic                          clk,
    input  logic [$clog2(PROG_DEPTH)-1:0] step_index,  // current entry of both engines
    input  logic                          rd_chan,
    input  logic [$clog2(PROG_DEPTH)-1:0] rd_index,
    output logic [vecgen_pkg::WORD_W-1:0] x_word,
    output logic [vecgen_pkg::WORD_W-1:0] y_word,
    output logic [vecgen_pkg::WORD_W-1:0] rd_word,
    prog_wr_if.store                      prog_wr
);

    // [0] holds channel x, [1] holds channel y
    logic [vecgen_pkg::WORD_W-1:0] mem [0:1][0:PROG_DEPTH-1];

    always_ff @(posedge clk) begin
        if (prog_wr.we)
            mem[prog_wr.chan][prog_wr.index] <= prog_wr.word;
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////
    assign x_word  = mem[0][step_index];
    assign y_word  = mem[1][step_index];
    assign rd_word = mem[rd_chan][rd_index];  // bus readback

endmodule

/* logic/segment_engine.sv */
// executes one program entry per step and moves one channel level; instantiated once per channel
`timescale 1ns/1ps

module segment_engine (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [vecgen_pkg::WORD_W-1:0]  word,   // entry at the current step index
    output logic [vecgen_pkg::LEVEL_W-1:0] level,
    chan_step_if.engine                    step
);

    // phase encoding
    localparam logic [2:0] PH_INIT = 3'd0;
    localparam logic [2:0] PH_1    = 3'd1;
    localparam logic [2:0] PH_4    = 3'd4;
    localparam logic [2:0] PH_FIN  = 3'd5;

    // per-clock action on the level
    localparam logic [1:0] ACT_HOLD = 2'd0;
    localparam logic [1:0] ACT_UP   = 2'd1;
    localparam logic [1:0] ACT_DOWN = 2'd2;

    logic [vecgen_pkg::OP_W-1:0]    op;
    logic [vecgen_pkg::LEVEL_W-1:0] pa, pb, pc;
    logic [2:0]                     phase;
    logic [2:0]                     last_phase;
    logic [vecgen_pkg::LEVEL_W-1:0] cnt;       // steps taken in this phase
    logic [vecgen_pkg::LEVEL_W-1:0] seg_len;
    logic [1:0]                     seg_act;

    assign op = word[vecgen_pkg::OP_LSB +: vecgen_pkg::OP_W];
    assign pa = word[vecgen_pkg::PA_LSB +: vecgen_pkg::LEVEL_W];
    assign pb = word[vecgen_pkg::PB_LSB +: vecgen_pkg::LEVEL_W];
    assign pc = word[vecgen_pkg::PC_LSB +: vecgen_pkg::LEVEL_W];

    assign step.done = (phase == PH_FIN);

    // rectangles run four phases, the rest one
    assign last_phase = (op == vecgen_pkg::OP_X_RECT || op == vecgen_pkg::OP_Y_RECT) ? PH_4 : PH_1;

    ////////////////////////////////////////
    // length and action of the current phase
    ////////////////////////////////////////
    always_comb begin
        seg_len = '0;
        seg_act = ACT_HOLD;
        case (op)
            vecgen_pkg::OP_LINE:   begin seg_len = pb; seg_act = ACT_UP;   end
            vecgen_pkg::OP_LINE_D: begin seg_len = pb; seg_act = ACT_DOWN; end
            vecgen_pkg::OP_INCR:   begin seg_len = pa; seg_act = ACT_UP;   end
            vecgen_pkg::OP_DCRE:   begin seg_len = pa; seg_act = ACT_DOWN; end
            vecgen_pkg::OP_X_RECT: begin
                seg_len = phase[0] ? pa : pb;  // odd phases move, even phases hold
                if (phase == 3'd1)
                    seg_act = ACT_UP;
                else if (phase == 3'd3)
                    seg_act = ACT_DOWN;
            end
            vecgen_pkg::OP_Y_RECT: begin
                seg_len = phase[0] ? pa : pb;  // odd phases hold
                if (phase == 3'd2)
                    seg_act = ACT_UP;
                else if (phase == 3'd4)
                    seg_act = ACT_DOWN;
            end
            default: ;                         // nop and jump finish from init
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            level <= '0;
            phase <= PH_INIT;
            cnt   <= '0;
        end else if (step.restart || step.ack) begin
            phase <= PH_INIT;                  // level is kept
            cnt   <= '0;
        end else if (step.run && !step.done) begin
            if (phase == PH_INIT) begin
                cnt <= '0;
                case (op)
                    vecgen_pkg::OP_NOP: phase <= PH_FIN;
                    vecgen_pkg::OP_JUMP: begin
                        level <= pa;
                        phase <= PH_FIN;
                    end
                    vecgen_pkg::OP_LINE, vecgen_pkg::OP_LINE_D: begin
                        level <= pa;           // start point of the line
                        phase <= PH_1;
                    end
                    default: phase <= PH_1;
                endcase
            end else if (cnt == seg_len) begin
                cnt   <= '0;
                phase <= (phase == last_phase) ? PH_FIN : phase + 3'd1;
            end else begin
                cnt <= cnt + 1'b1;
                if (seg_act == ACT_UP)
                    level <= level + pc;       // wraps modulo 256
                else if (seg_act == ACT_DOWN)
                    level <= level - pc;
            end
        end
    end

endmodule

/* logic/sequence_ctrl.sv */
// instruction pointer and lockstep control, acks both engines only once both have finished
`timescale 1ns/1ps

module sequence_ctrl #(
    parameter int PROG_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          restart,     // one clock pulse from the bus port
    output logic [$clog2(PROG_DEPTH)-1:0] step_index,
    chan_step_if.ctrl                     x_step,
    chan_step_if.ctrl                     y_step
);

    logic both_done;
    logic pend;     // both done seen on the previous clock
    logic ack;

    assign both_done = x_step.done && y_step.done;
    assign ack       = pend && run;    // held off while frozen

    assign x_step.run     = run;
    assign y_step.run     = run;
    assign x_step.restart = restart;
    assign y_step.restart = restart;
    assign x_step.ack     = ack;
    assign y_step.ack     = ack;

    ////////////////////////////////////////
    // step pointer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            step_index <= '0;
            pend       <= 1'b0;
        end else begin
            pend <= both_done && !ack;
            if (ack)
                step_index <= step_index + 1'b1;  // depth is a power of two so this wraps
        end
    end

endmodule

/* logic/vecgen_top.sv */
// top level of the XY vector generator, AXI4-Lite program port in and two DAC levels out
`timescale 1ns/1ps

module vecgen_top #(
    parameter int PROG_DEPTH = 16
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [vecgen_pkg::AXI_ADDR_W-1:0]  awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [vecgen_pkg::WORD_W-1:0]      wdata,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [vecgen_pkg::RESP_W-1:0]      bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [vecgen_pkg::AXI_ADDR_W-1:0]  araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [vecgen_pkg::WORD_W-1:0]      rdata,
    output logic [vecgen_pkg::RESP_W-1:0]      rresp,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [vecgen_pkg::LEVEL_W-1:0]     x_level,
    output logic [vecgen_pkg::LEVEL_W-1:0]     y_level,
    output logic [$clog2(PROG_DEPTH)-1:0]      step_index
);

    logic [vecgen_pkg::WORD_W-1:0] rd_word;
    logic                          rd_chan;
    logic [$clog2(PROG_DEPTH)-1:0] rd_index;
    logic [vecgen_pkg::WORD_W-1:0] x_word, y_word;
    logic                          run, restart;

    prog_wr_if #(.PROG_DEPTH(PROG_DEPTH)) prog_wr ();
    chan_step_if x_step ();
    chan_step_if y_step ();

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////
    axil_prog_port #(.PROG_DEPTH(PROG_DEPTH)) i_prog_port (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .rd_word(rd_word), .rd_chan(rd_chan), .rd_index(rd_index),
        .run(run), .restart(restart),
        .prog_wr(prog_wr)
    );

    program_store #(.PROG_DEPTH(PROG_DEPTH)) i_store (
        .clk(clk), .step_index(step_index),
        .rd_chan(rd_chan), .rd_index(rd_index),
        .x_word(x_word), .y_word(y_word), .rd_word(rd_word),
        .prog_wr(prog_wr)
    );

    // sequencer and the two channel engines
    sequence_ctrl #(.PROG_DEPTH(PROG_DEPTH)) i_seq_ctrl (
        .clk(clk), .reset(reset), .run(run), .restart(restart),
        .step_index(step_index), .x_step(x_step), .y_step(y_step)
    );

    segment_engine i_x_engine (
        .clk(clk), .reset(reset), .word(x_word), .level(x_level), .step(x_step)
    );

    segment_engine i_y_engine (
        .clk(clk), .reset(reset), .word(y_word), .level(y_level), .step(y_step)
    );

endmodule

/* dv/vecgen_chk.sv */
// concurrent protocol and lockstep assertions, bound into vecgen_top from the testbench build
`timescale 1ns/1ps

module vecgen_chk #(
    parameter int PROG_DEPTH = 16
) (
    input logic                          clk,
    input logic                          reset,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          rvalid,
    input logic                          rready,
    input logic                          run,
    input logic                          ack,
    input logic                          x_done,
    input logic                          y_done,
    input logic [7:0]                    x_level,
    input logic [7:0]                    y_level,
    input logic [$clog2(PROG_DEPTH)-1:0] step_index
);

    // responses stay up until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    a_ack_lockstep: assert property (@(posedge clk) disable iff (reset)
        ack |-> x_done && y_done) else $error("ack without both channels done");

    ////////////////////////////////////////
    // frozen while stopped
    ////////////////////////////////////////
    a_freeze: assert property (@(posedge clk) disable iff (reset)
        !run |=> $stable(x_level) && $stable(y_level)) else $error("level moved while stopped");

    a_step: assert property (@(posedge clk) disable iff (reset)
        $changed(step_index) |-> (step_index == '0)
            || (step_index == $clog2(PROG_DEPTH)'($past(step_index) + 1)))
        else $error("step index jumped");

endmodule

bind vecgen_top vecgen_chk #(.PROG_DEPTH(PROG_DEPTH)) i_chk (
    .clk(clk), .reset(reset),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
    .run(run), .ack(x_step.ack), .x_done(x_step.done), .y_done(y_step.done),
    .x_level(x_level), .y_level(y_level), .step_index(step_index)
);

/* dv/vecgen_tb.sv */
// testbench for vecgen_top that loads programs over AXI4-Lite and checks levels against a model
`timescale 1ns/1ps

module vecgen_tb;

    localparam int DEPTH     = 16;
    localparam int MAX_CYCLE = 20000;   // 5 tests of up to 32 entries of 62 clocks plus bus traffic

    logic                               clk, reset;
    logic [vecgen_pkg::AXI_ADDR_W-1:0]  awaddr, araddr;
    logic                               awvalid, awready, wvalid, wready, bvalid, bready;
    logic [vecgen_pkg::WORD_W-1:0]      wdata, rdata;
    logic [vecgen_pkg::RESP_W-1:0]      bresp, rresp;
    logic                               arvalid, arready, rvalid, rready;
    logic [vecgen_pkg::LEVEL_W-1:0]     x_level, y_level;
    logic [$clog2(DEPTH)-1:0]           step_index;

    int                                 seed = 78;
    int                                 cycles = 0;
    logic [vecgen_pkg::WORD_W-1:0]      xp [DEPTH];
    logic [vecgen_pkg::WORD_W-1:0]      yp [DEPTH];
    logic [vecgen_pkg::LEVEL_W-1:0]     x_model = '0;
    logic [vecgen_pkg::LEVEL_W-1:0]     y_model = '0;

    vecgen_top #(.PROG_DEPTH(DEPTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("run did not finish within %0d cycles", MAX_CYCLE);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // model and compare tasks
    ////////////////////////////////////////
    function automatic logic [31:0] make_word(input logic [2:0] op, input logic [7:0] a, b, c);
        return {5'b0, op, a, b, c};
    endfunction

    // level at the end of one entry from the opcode table
    function automatic logic [7:0] final_level(input logic [7:0] v, input logic [31:0] w);
        logic [7:0] a, b, c;
        a = w[23:16];
        b = w[15:8];
        c = w[7:0];
        case (w[26:24])
            vecgen_pkg::OP_JUMP:   return a;
            vecgen_pkg::OP_LINE:   return a + b * c;
            vecgen_pkg::OP_LINE_D: return a - b * c;
            vecgen_pkg::OP_INCR:   return v + a * c;
            vecgen_pkg::OP_DCRE:   return v - a * c;
            default:               return v;   // nop and both rectangles end where they start
        endcase
    endfunction

    task automatic check_level(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_index(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "index mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "handshake mismatch");
        end
    endtask

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!awready);
        check_flag("wready", 1'b1, wready);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(negedge clk); while (!bvalid);
        check_resp("bresp", exp_resp, bresp);
        @(posedge clk);     // response waits one clock before it is taken
        #2;
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        check_resp("rresp", exp_resp, rresp);
        check_word("rdata", exp_data, rdata);
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < DEPTH; i++) begin
            axil_write(8'(i * 4), xp[i], vecgen_pkg::RESP_OKAY);
            axil_write(8'(64 + i * 4), yp[i], vecgen_pkg::RESP_OKAY);
        end
    endtask

    // level check at each step change against the model's end of the previous entry
    task automatic run_steps(input int n);
        logic [3:0] cur;
        cur = '0;
        for (int k = 0; k < n; k++) begin
            do @(negedge clk); while (step_index == cur);
            x_model = final_level(x_model, xp[cur]);
            y_model = final_level(y_model, yp[cur]);
            check_level("x_level", x_model, x_level);
            check_level("y_level", y_model, y_level);
            check_index("step_index", cur + 4'd1, step_index);
            cur = cur + 4'd1;
        end
    endtask

    task automatic run_program();
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h2, vecgen_pkg::RESP_OKAY);  // stop and restart
        load_program();
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h1, vecgen_pkg::RESP_OKAY);
        run_steps(DEPTH);
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h0, vecgen_pkg::RESP_OKAY);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_readback();
        logic [31:0] w0, w1;
        w0 = make_word(vecgen_pkg::OP_LINE, 8'($random(seed)), 8'h0c, 8'h05);
        w1 = make_word(vecgen_pkg::OP_Y_RECT, 8'h03, 8'($random(seed)), 8'h11);
        axil_write(8'h0c, w0, vecgen_pkg::RESP_OKAY);
        axil_write(8'h4c, w1, vecgen_pkg::RESP_OKAY);       // same index on y
        axil_read(8'h0c, w0, vecgen_pkg::RESP_OKAY);
        axil_read(8'h4c, w1, vecgen_pkg::RESP_OKAY);
        axil_write(8'h8c, 32'hffff_ffff, vecgen_pkg::RESP_SLVERR);
        axil_read(8'h8c, 32'h0, vecgen_pkg::RESP_SLVERR);
        axil_read(8'h42, 32'h0, vecgen_pkg::RESP_SLVERR);   // unaligned
        axil_read(8'h0c, w0, vecgen_pkg::RESP_OKAY);
    endtask

    task automatic test_lines();
        for (int i = 0; i < DEPTH; i++) begin
            case (i % 4)
                0: begin
                    xp[i] = make_word(vecgen_pkg::OP_JUMP, 8'(i * 13), 8'h0, 8'h0);
                    yp[i] = make_word(vecgen_pkg::OP_JUMP, 8'(200 - i), 8'h0, 8'h0);
                end
                1: begin
                    xp[i] = make_word(vecgen_pkg::OP_LINE, 8'(i * 16), 8'(i), 8'h03);
                    yp[i] = make_word(vecgen_pkg::OP_LINE_D, 8'h10, 8'h0f, 8'h07);
                end
                2: begin
                    xp[i] = make_word(vecgen_pkg::OP_LINE_D, 8'h08, 8'(i), 8'h21);
                    yp[i] = make_word(vecgen_pkg::OP_LINE, 8'hf0, 8'h00, 8'h09);
                end
                default: begin
                    xp[i] = make_word(vecgen_pkg::OP_NOP, 8'h55, 8'h0, 8'h0);
                    yp[i] = make_word(vecgen_pkg::OP_LINE, 8'h80, 8'h0a, 8'h30);
                end
            endcase
        end
        run_program();
    endtask

    task automatic test_incr_dcre();
        xp[0] = make_word(vecgen_pkg::OP_JUMP, 8'($random(seed)), 8'h0, 8'h0);
        yp[0] = make_word(vecgen_pkg::OP_JUMP, 8'($random(seed)), 8'h0, 8'h0);
        for (int i = 1; i < DEPTH; i++) begin
            xp[i] = make_word(i[0] ? vecgen_pkg::OP_INCR : vecgen_pkg::OP_DCRE,
                              8'($random(seed) & 15), 8'h0, 8'($random(seed)));
            yp[i] = make_word(i[0] ? vecgen_pkg::OP_DCRE : vecgen_pkg::OP_INCR,
                              8'($random(seed) & 15), 8'h0, 8'($random(seed)));
        end
        run_program();
    endtask

    task automatic test_rects();
        xp[0] = make_word(vecgen_pkg::OP_JUMP, 8'h40, 8'h0, 8'h0);
        yp[0] = make_word(vecgen_pkg::OP_JUMP, 8'hc0, 8'h0, 8'h0);
        for (int i = 1; i < DEPTH; i++) begin
            // lengths cross over, so each channel is the long one in half the entries
            xp[i] = make_word(vecgen_pkg::OP_X_RECT, 8'(i), 8'h02, 8'(i * 7));
            yp[i] = make_word(vecgen_pkg::OP_Y_RECT, 8'h01, 8'(15 - i), 8'h13);
        end
        run_program();
    endtask

    task automatic test_freeze_restart();
        logic [7:0] hold_x, hold_y;
        logic [3:0] hold_i;
        test_lines();
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h2, vecgen_pkg::RESP_OKAY);
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h1, vecgen_pkg::RESP_OKAY);
        do @(negedge clk); while (step_index != 4'd3);
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h0, vecgen_pkg::RESP_OKAY);
        hold_x = x_level;
        hold_y = y_level;
        hold_i = step_index;
        repeat (20) @(negedge clk);
        check_level("x_level", hold_x, x_level);
        check_level("y_level", hold_y, y_level);
        check_index("step_index", hold_i, step_index);
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h2, vecgen_pkg::RESP_OKAY);
        @(negedge clk);
        check_index("step_index", 4'd0, step_index);
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h1, vecgen_pkg::RESP_OKAY);
        run_steps(DEPTH);                       // entry 0 is a jump, so the model resyncs
        axil_write(vecgen_pkg::CTRL_ADDR, 32'h0, vecgen_pkg::RESP_OKAY);
    endtask

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        test_readback();
        test_lines();
        test_incr_dcre();
        test_rects();
        test_freeze_restart();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* project.f */
logic/vecgen_pkg.sv
logic/vecgen_ifs.sv
logic/axil_prog_port.sv
logic/program_store.sv
logic/segment_engine.sv
logic/sequence_ctrl.sv
logic/vecgen_top.sv
dv/vecgen_chk.sv
dv/vecgen_tb.sv

/* Bender.yml */
package:
  name: vecgen

sources:
  - logic/vecgen_pkg.sv
  - logic/vecgen_ifs.sv
  - logic/axil_prog_port.sv
  - logic/program_store.sv
  - logic/segment_engine.sv
  - logic/sequence_ctrl.sv
  - logic/vecgen_top.sv
  - target: simulation
    files:
      - dv/vecgen_chk.sv
      - dv/vecgen_tb.sv
